/* Bender.yml */
package:
  name: vector_add

sources:
  - source/operand_pkg.sv
  - source/sum_pkg.sv
  - source/lane_align.sv
  - source/special_detect.sv
  - source/term_reduce.sv
  - source/result_pack.sv
  - source/vector_add_top.sv
  - target: test
    files:
      - dv/clock_gen.sv
      - dv/vector_add_tb.sv

/* dv/clock_gen.sv */
module clock_gen #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk; // free running

endmodule

/* dv/vector_add_tb.sv */
module vector_add_tb;
    import operand_pkg::*;
    import sum_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_VECTORS  = 64; // all vectors of all tests plus some margin

    logic                              clk;
    logic                              rst;
    mode_t                             op_mode;
    emax_t                             e_max;
    scale_t                            ab_scale;
    esub_t      [NUM_LANES-1:0]        ae_sub;
    esub_t      [NUM_LANES-1:0]        be_sub;
    logic       [NUM_LANES-1:0]        a_e_overflow;
    logic       [NUM_LANES-1:0]        b_e_overflow;
    lane_word_t [NUM_LANES-1:0]        a_m;
    result_t                           z;

    // expected results in flight in drive order
    result_t exp_q[$];
    int      idx_q[$];
    string   tag_q[$];
    int      fall_cnt;
    int      checks_done;

    clock_gen #(.PERIOD(CLK_PERIOD)) u_clk (.clk(clk));

    vector_add_top uut (
        .clk          (clk),
        .rst          (rst),
        .op_mode      (op_mode),
        .e_max        (e_max),
        .ab_scale     (ab_scale),
        .ae_sub       (ae_sub),
        .be_sub       (be_sub),
        .a_e_overflow (a_e_overflow),
        .b_e_overflow (b_e_overflow),
        .a_m          (a_m),
        .z            (z)
    );

    // value-level model of one dot-product step
    function automatic result_t model_result(
        input mode_t                      mode,
        input emax_t                      emax,
        input scale_t                     scale,
        input esub_t      [NUM_LANES-1:0] asub,
        input esub_t      [NUM_LANES-1:0] bsub,
        input logic       [NUM_LANES-1:0] aovf,
        input logic       [NUM_LANES-1:0] bovf,
        input lane_word_t [NUM_LANES-1:0] am
    );
        longint      acc;
        longint      b;
        longint      q;
        int          sh;
        int          e;
        logic [15:0] h;
        esub_t       sub;
        logic        ovf;
        logic        all_zero;
        logic        any_nan;
        logic        any_pinf;
        logic        any_ninf;
        logic        nan_f;
        logic        inf_f;
        logic [31:0] sum32;
        logic [9:0]  exp10;
        begin
            acc      = 0;
            all_zero = 1'b1;
            any_nan  = 1'b0;
            any_pinf = 1'b0;
            any_ninf = 1'b0;
            for (int i = 0; i < 2 * NUM_LANES; i++) begin
                h   = (i % 2 == 0) ? am[i / 2][31:16] : am[i / 2][15:0]; // even i is the a half
                sub = (i % 2 == 0) ? asub[i / 2] : bsub[i / 2];
                ovf = (i % 2 == 0) ? aovf[i / 2] : bovf[i / 2];
                if (mode == MODE_INT8) begin
                    acc = acc + longint'($signed(h));
                end else if (mode == MODE_FP8) begin
                    b  = longint'($signed(h[8:0])) * 131072; // mantissa times 2**17
                    sh = int'(sub[4:0]);
                    q  = b >>> sh;
                    if (!ovf) begin
                        acc = acc + q * 2 + ((b != (q <<< sh)) ? 1 : 0); // sticky as lsb
                    end
                    all_zero = all_zero & h[11];
                    any_nan  = any_nan | h[9];
                    any_pinf = any_pinf | (h[10] & ~h[8]);
                    any_ninf = any_ninf | (h[10] & h[8]);
                end
            end
            sum32 = acc[31:0];
            nan_f = any_nan | (any_pinf & any_ninf);
            inf_f = (any_pinf | any_ninf) & ~nan_f;
            e     = int'($signed(emax)) + 5 + int'($signed(scale));
            exp10 = e[9:0];
            if (mode == MODE_INT8) begin
                model_result = {25'b0, sum32[20:0]};
            end else if (mode == MODE_FP8) begin
                model_result = {all_zero, inf_f, nan_f, exp10,
                                inf_f ? any_ninf : sum32[31], sum32};
            end else begin
                model_result = '0;
            end
        end
    endfunction

    function automatic logic [15:0] fp8_half(input logic [2:0] status, input mant_t mant);
        begin
            fp8_half = {4'b0, status, mant};
        end
    endfunction

    task automatic stop_on_error(input string msg);
        begin
            $display("FAIL at time %0t: %s", $time, msg);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // one falling edge and the check of the vector driven two edges back
    task automatic tick();
        result_t expected;
        string   tag;
        begin
            @(negedge clk);
            fall_cnt++;
            if (idx_q.size() > 0 && idx_q[0] == fall_cnt - 2) begin
                expected = exp_q.pop_front();
                tag      = tag_q.pop_front();
                void'(idx_q.pop_front());
                checks_done++;
                assert (z === expected) else
                    stop_on_error($sformatf("%s: z=%h expected %h", tag, z, expected));
            end
        end
    endtask

    task automatic queue_expected(input string tag);
        begin
            exp_q.push_back(model_result(op_mode, e_max, ab_scale, ae_sub, be_sub,
                                         a_e_overflow, b_e_overflow, a_m));
            idx_q.push_back(fall_cnt);
            tag_q.push_back(tag);
        end
    endtask

    task automatic drain();
        begin
            while (idx_q.size() > 0) begin
                tick();
            end
        end
    endtask

    task automatic randomize_operands(input logic [31:0] word_mask);
        begin
            e_max        = $urandom();
            ab_scale     = $urandom();
            a_e_overflow = '0;
            b_e_overflow = '0;
            for (int i = 0; i < NUM_LANES; i++) begin
                a_m[i]    = $urandom() & word_mask;
                ae_sub[i] = $urandom(); // top bit is random and must not shift
                be_sub[i] = $urandom();
            end
        end
    endtask

    task automatic check_flags(input logic zero, input logic inf, input logic nan,
                               input string tag);
        begin
            assert (z[45] === zero && z[44] === inf && z[43] === nan) else
                stop_on_error($sformatf("%s: flags %b%b%b expected %b%b%b",
                                        tag, z[45], z[44], z[43], zero, inf, nan));
        end
    endtask

    task automatic test_reset_state();
        begin
            tick();
            assert (z === '0) else
                stop_on_error($sformatf("reset: z=%h expected zero", z));
        end
    endtask

    task automatic test_int8_sum();
        begin
            for (int n = 0; n < 20; n++) begin
                tick();
                randomize_operands(32'hFFFF_FFFF);
                op_mode = MODE_INT8;
                queue_expected("int8 sum");
            end
            drain();
        end
    endtask

    task automatic test_fp8_align();
        begin
            for (int n = 0; n < 20; n++) begin
                tick();
                randomize_operands(32'h01FF_01FF); // status bits cleared
                op_mode = MODE_FP8;
                queue_expected("fp8 align");
            end
            drain();
        end
    endtask

    task automatic test_overflow();
        begin
            for (int n = 0; n < 12; n++) begin
                tick();
                randomize_operands(32'h01FF_01FF);
                op_mode      = MODE_FP8;
                a_e_overflow = $urandom();
                b_e_overflow = $urandom();
                queue_expected("fp8 overflow");
            end
            tick();
            randomize_operands(32'h01FF_01FF);
            op_mode      = MODE_FP8;
            a_e_overflow = '1;
            b_e_overflow = '1;
            queue_expected("fp8 all overflow");
            drain();
            assert (z[31:0] === '0) else
                stop_on_error($sformatf("all overflow: sum=%h expected zero", z[31:0]));
        end
    endtask

    task automatic test_special_values();
        begin
            tick();
            randomize_operands('0);
            op_mode = MODE_FP8;
            for (int i = 0; i < NUM_LANES; i++) begin
                a_m[i] = {fp8_half(3'b100, '0), fp8_half(3'b100, '0)};
            end
            queue_expected("fp8 all zero");
            drain();
            check_flags(1'b1, 1'b0, 1'b0, "fp8 all zero");

            tick();
            randomize_operands(32'h01FF_01FF);
            op_mode        = MODE_FP8;
            a_m[5][15:0]   = fp8_half(3'b001, $urandom());
            queue_expected("fp8 nan");
            drain();
            check_flags(1'b0, 1'b0, 1'b1, "fp8 nan");

            tick();
            randomize_operands(32'h01FF_01FF);
            op_mode        = MODE_FP8;
            a_m[2][31:16]  = fp8_half(3'b010, 9'h040); // +inf
            a_m[9][15:0]   = fp8_half(3'b010, 9'h1C0); // -inf
            queue_expected("fp8 inf pair");
            drain();
            check_flags(1'b0, 1'b0, 1'b1, "fp8 inf pair");

            tick();
            randomize_operands(32'h00FF_00FF); // non-negative mantissas
            op_mode         = MODE_FP8;
            a_m[7][31:16]   = fp8_half(3'b010, 9'h180);
            a_e_overflow[7] = 1'b1; // sum stays positive and the sign must come from the inf
            queue_expected("fp8 neg inf");
            drain();
            check_flags(1'b0, 1'b1, 1'b0, "fp8 neg inf");
            assert (z[32] === 1'b1) else
                stop_on_error($sformatf("fp8 neg inf: sign=%b expected 1", z[32]));
        end
    endtask

    task automatic test_unsupported_mode();
        mode_t bad_modes[5] = '{4'b0000, 4'b0100, 4'b1000, 4'b0011, 4'b1111};
        begin
            for (int n = 0; n < 5; n++) begin
                tick();
                randomize_operands(32'hFFFF_FFFF);
                op_mode = bad_modes[n];
                queue_expected("unsupported mode");
            end
            drain();
        end
    endtask

    initial begin
        #(NUM_VECTORS * 40 * CLK_PERIOD);
        $display("ERROR: simulation timed out before the tests finished");
        $display("Result: FAILED");
        $fatal(1);
    end

    initial begin
        rst          = 1'b1;
        op_mode      = '0;
        e_max        = '0;
        ab_scale     = '0;
        ae_sub       = '0;
        be_sub       = '0;
        a_e_overflow = '0;
        b_e_overflow = '0;
        a_m          = '0;
        fall_cnt     = 0;
        checks_done  = 0;
        void'($urandom(81471));

        // busy fp8 inputs while reset is held
        randomize_operands(32'hFFFF_FFFF);
        op_mode = MODE_FP8;

        @(posedge clk);
        repeat (RESET_CYCLES) tick();
        rst     = 1'b0;
        op_mode = '0; // idle mode after release

        test_reset_state();
        test_int8_sum();
        test_fp8_align();
        test_overflow();
        test_special_values();
        test_unsupported_mode();

        if (idx_q.size() == 0 && checks_done > 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Result: FAILED");
            $fatal(1, "checks left pending at the end of the run");
        end
    end

endmodule

/* project.f */
source/operand_pkg.sv
source/sum_pkg.sv
source/lane_align.sv
source/special_detect.sv
source/term_reduce.sv
source/result_pack.sv
source/vector_add_top.sv
dv/clock_gen.sv
dv/vector_add_tb.sv

/* source/lane_align.sv */
module lane_align (
    input  operand_pkg::mode_t      op_mode,
    input  operand_pkg::lane_word_t word,
    input  operand_pkg::esub_t      sub_hi,
    input  operand_pkg::esub_t      sub_lo,
    input  logic                    ovf_hi,
    input  logic                    ovf_lo,
    output sum_pkg::term_t          term_hi,
    output sum_pkg::term_t          term_lo
);
    import operand_pkg::*;
    import sum_pkg::*;

    // mantissa goes to bits 31:1, shifted by its exponent gap, sticky in bit 0
    function automatic term_t align_fp8(input mant_t mant, input esub_t sub, input logic ovf);
        logic [TERM_W-2:0]  body;
        logic [TERM_W-2:0]  shifted;
        logic [TERM_W-2:0]  lost_mask;
        logic [SHIFT_W-1:0] sh;
        logic               sticky;
        begin
            sh        = sub[SHIFT_W-1:0];
            body      = {{(TERM_W-1-MANT_W-FRAC_PAD){mant[MANT_W-1]}}, mant, {FRAC_PAD{1'b0}}};
            shifted   = $signed(body) >>> sh;
            lost_mask = ~({(TERM_W-1){1'b1}} << sh); // bits that fall off the bottom
            sticky    = |(body & lost_mask);
            if (ovf) begin
                align_fp8 = '0; // exponent overflow drops the half
            end else begin
                align_fp8 = {shifted, sticky};
            end
        end
    endfunction

    function automatic term_t sext_int(input int_prod_t prod);
        begin
            sext_int = {{(TERM_W-HALF_W){prod[HALF_W-1]}}, prod};
        end
    endfunction

    always_comb begin
        case (op_mode)
            MODE_FP8: begin
                term_hi = align_fp8(word[HALF_W +: MANT_W], sub_hi, ovf_hi);
                term_lo = align_fp8(word[0 +: MANT_W], sub_lo, ovf_lo);
            end
            MODE_INT8: begin
                term_hi = sext_int(word[HALF_W +: HALF_W]);
                term_lo = sext_int(word[0 +: HALF_W]);
            end
            default: begin
                term_hi = '0;
                term_lo = '0;
            end
        endcase
    end

endmodule

/* source/operand_pkg.sv */
package operand_pkg;

    // op_mode codes, one-hot
    localparam int MODE_W = 4;
    typedef logic [MODE_W-1:0] mode_t;

    localparam mode_t MODE_INT8 = 4'b0001;
    localparam mode_t MODE_FP8  = 4'b0010;

    // one lane carries two products, hi half at 31:16, lo half at 15:0
    localparam int HALF_W = 16;
    typedef logic [2*HALF_W-1:0] lane_word_t;

    // fp8 fields inside one half
    localparam int MANT_W  = 9;  // sign at the top bit
    localparam int ST_LSB  = 9;
    localparam int ST_W    = 3;
    localparam int ST_ZERO = 2;
    localparam int ST_INF  = 1;
    localparam int ST_NAN  = 0;

    typedef logic [MANT_W-1:0] mant_t;
    typedef logic [HALF_W-1:0] int_prod_t; // int8 product fills a whole half

    // exponent difference, only the low bits shift
    localparam int SHIFT_W = 5;
    typedef logic [5:0] esub_t;

    localparam int SCALE_W = 9;
    localparam int EMAX_W  = 9;
    typedef logic [SCALE_W-1:0] scale_t; // signed block scale
    typedef logic [EMAX_W-1:0]  emax_t;  // signed

endpackage

/* source/result_pack.sv */
module result_pack (
    input  logic                clk,
    input  logic                rst,
    input  operand_pkg::mode_t  op_mode,
    input  operand_pkg::emax_t  e_max,
    input  operand_pkg::scale_t ab_scale,
    input  sum_pkg::term_t      sum,
    input  logic                z_zero,
    input  logic                z_inf,
    input  logic                z_nan,
    input  logic                inf_neg,
    output operand_pkg::mode_t  mode_r,
    output sum_pkg::result_t    z
);
    import operand_pkg::*;
    import sum_pkg::*;

    exp_t    exp_next;
    exp_t    exp_r;
    logic    sign;
    result_t z_next;

    // signed e_max + bias + block scale, wraps to EXP_W bits
    assign exp_next = {{(EXP_W-EMAX_W){e_max[EMAX_W-1]}}, e_max} + EXP_BIAS
                    + {{(EXP_W-SCALE_W){ab_scale[SCALE_W-1]}}, ab_scale};

    // stage 1
    always_ff @(posedge clk) begin
        if (rst) begin
            mode_r <= '0;
        end else begin
            mode_r <= op_mode;
        end
    end

    always_ff @(posedge clk) begin
        exp_r <= exp_next;
    end

    assign sign = z_inf ? inf_neg : sum[TERM_W-1]; // inf keeps its own sign

    always_comb begin
        case (mode_r)
            MODE_FP8: begin
                z_next = {z_zero, z_inf, z_nan, exp_r, sign, sum};
            end
            MODE_INT8: begin
                z_next = {{(RESULT_W-INT_SUM_W){1'b0}}, sum[INT_SUM_W-1:0]};
            end
            default: begin
                z_next = '0;
            end
        endcase
    end

    // stage 2
    always_ff @(posedge clk) begin
        z <= z_next;
    end

endmodule

/* source/special_detect.sv */
module special_detect (
    input  logic                                              clk,
    input  logic                                              rst,
    input  operand_pkg::mode_t                                op_mode,
    input  operand_pkg::lane_word_t [sum_pkg::NUM_LANES-1:0] a_m,
    output logic                                              z_zero,
    output logic                                              z_inf,
    output logic                                              z_nan,
    output logic                                              inf_neg
);
    import operand_pkg::*;
    import sum_pkg::*;

    logic              all_zero;
    logic              any_nan;
    logic              any_pinf;
    logic              any_ninf;
    logic [HALF_W-1:0] half;
    logic [ST_W-1:0]   st;
    logic              is_fp8;
    logic              nan_c;
    logic              inf_c;

    // scan both halves of every lane
    always_comb begin
        all_zero = 1'b1;
        any_nan  = 1'b0;
        any_pinf = 1'b0;
        any_ninf = 1'b0;
        half     = '0;
        st       = '0;
        for (int i = 0; i < 2 * NUM_LANES; i++) begin
            half     = a_m[i / 2][(i % 2) * HALF_W +: HALF_W];
            st       = half[ST_LSB +: ST_W];
            all_zero = all_zero & st[ST_ZERO];
            any_nan  = any_nan | st[ST_NAN];
            any_pinf = any_pinf | (st[ST_INF] & ~half[MANT_W-1]);
            any_ninf = any_ninf | (st[ST_INF] & half[MANT_W-1]);
        end
    end

    assign is_fp8 = (op_mode == MODE_FP8);
    assign nan_c  = is_fp8 & (any_nan | (any_pinf & any_ninf)); // +inf and -inf together
    assign inf_c  = is_fp8 & (any_pinf | any_ninf) & ~nan_c;

    always_ff @(posedge clk) begin
        if (rst) begin
            z_zero  <= 1'b0;
            z_inf   <= 1'b0;
            z_nan   <= 1'b0;
            inf_neg <= 1'b0;
        end else begin
            z_zero  <= is_fp8 & all_zero;
            z_inf   <= inf_c;
            z_nan   <= nan_c;
            inf_neg <= inf_c & any_ninf;
        end
    end

endmodule

/* source/sum_pkg.sv */
package sum_pkg;

    localparam int NUM_LANES = 16;

    // aligned term, sticky bit at bit 0 in fp8 mode
    localparam int TERM_W = 32;
    typedef logic [TERM_W-1:0] term_t;

    // zero bits below the fp8 mantissa before alignment
    localparam int FRAC_PAD = 17;

    localparam int HALF_SUM_W = 32;
    typedef logic [HALF_SUM_W-1:0] half_sum_t;

    // int8 half sums are valid up to this width
    localparam int INT_HALF_W = 20;
    localparam int INT_SUM_W  = 21;

    // result exponent
    localparam int EXP_W = 10;
    typedef logic [EXP_W-1:0] exp_t;

    localparam exp_t EXP_BIAS = 10'd5; // growth over 32 terms

    // z = {zero, inf, nan, exp, sign, sum}
    localparam int RESULT_W = 46;
    typedef logic [RESULT_W-1:0] result_t;

endpackage

/* source/term_reduce.sv */
module term_reduce (
    input  logic                                      clk,
    input  sum_pkg::term_t [sum_pkg::NUM_LANES-1:0] terms_hi,
    input  sum_pkg::term_t [sum_pkg::NUM_LANES-1:0] terms_lo,
    input  operand_pkg::mode_t                        mode_r,
    output sum_pkg::term_t                            sum
);
    import operand_pkg::*;
    import sum_pkg::*;

    half_sum_t hi_next;
    half_sum_t lo_next;
    half_sum_t hi_q;
    half_sum_t lo_q;
    half_sum_t hi_ext;
    half_sum_t lo_ext;

    // two 16-term trees, written as plain sums
    always_comb begin
        hi_next = '0;
        lo_next = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            hi_next = hi_next + terms_hi[i];
            lo_next = lo_next + terms_lo[i];
        end
    end

    always_ff @(posedge clk) begin
        hi_q <= hi_next;
        lo_q <= lo_next;
    end

    // int8 sums only hold INT_HALF_W valid bits
    always_comb begin
        if (mode_r == MODE_INT8) begin
            hi_ext = {{(HALF_SUM_W-INT_HALF_W){hi_q[INT_HALF_W-1]}}, hi_q[INT_HALF_W-1:0]};
            lo_ext = {{(HALF_SUM_W-INT_HALF_W){lo_q[INT_HALF_W-1]}}, lo_q[INT_HALF_W-1:0]};
        end else begin
            hi_ext = hi_q;
            lo_ext = lo_q;
        end
    end

    assign sum = hi_ext + lo_ext; // final add, after the stage-1 register

endmodule

/* source/vector_add_top.sv */
module vector_add_top (
    input  logic                                              clk,
    input  logic                                              rst,
    input  operand_pkg::mode_t                                op_mode,
    input  operand_pkg::emax_t                                e_max,
    input  operand_pkg::scale_t                               ab_scale,
    input  operand_pkg::esub_t      [sum_pkg::NUM_LANES-1:0] ae_sub,
    input  operand_pkg::esub_t      [sum_pkg::NUM_LANES-1:0] be_sub,
    input  logic                    [sum_pkg::NUM_LANES-1:0] a_e_overflow,
    input  logic                    [sum_pkg::NUM_LANES-1:0] b_e_overflow,
    input  operand_pkg::lane_word_t [sum_pkg::NUM_LANES-1:0] a_m,
    output sum_pkg::result_t                                  z
);
    import operand_pkg::*;
    import sum_pkg::*;

    term_t [NUM_LANES-1:0] terms_hi;
    term_t [NUM_LANES-1:0] terms_lo;
    term_t                 sum;
    mode_t                 mode_r;   // stage-1 mode from result_pack
    logic                  z_zero;
    logic                  z_inf;
    logic                  z_nan;
    logic                  inf_neg;

    // a half uses ae_sub, b half uses be_sub
    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
        lane_align u_lane (
            .op_mode (op_mode),
            .word    (a_m[i]),
            .sub_hi  (ae_sub[i]),
            .sub_lo  (be_sub[i]),
            .ovf_hi  (a_e_overflow[i]),
            .ovf_lo  (b_e_overflow[i]),
            .term_hi (terms_hi[i]),
            .term_lo (terms_lo[i])
        );
    end

    special_detect u_special (
        .clk     (clk),
        .rst     (rst),
        .op_mode (op_mode),
        .a_m     (a_m),
        .z_zero  (z_zero),
        .z_inf   (z_inf),
        .z_nan   (z_nan),
        .inf_neg (inf_neg)
    );

    term_reduce u_reduce (
        .clk      (clk),
        .terms_hi (terms_hi),
        .terms_lo (terms_lo),
        .mode_r   (mode_r),
        .sum      (sum)
    );

    result_pack u_pack (
        .clk      (clk),
        .rst      (rst),
        .op_mode  (op_mode),
        .e_max    (e_max),
        .ab_scale (ab_scale),
        .sum      (sum),
        .z_zero   (z_zero),
        .z_inf    (z_inf),
        .z_nan    (z_nan),
        .inf_neg  (inf_neg),
        .mode_r   (mode_r),
        .z        (z)
    );

endmodule
